/* hdl/lce_pkg.sv */
/*
 * LCE request-side definitions
 * sizes, message enums and the request/response words shared by the
 * miss engine blocks
 */
package lce_pkg;

  localparam int paddr_width = 32;
  localparam int data_width = 64;
  localparam int ways = 8;
  localparam int num_lce = 4;
  localparam int num_cce = 2;

  localparam int way_id_width = $clog2(ways);
  localparam int lce_id_width = $clog2(num_lce);
  localparam int cce_id_width = $clog2(num_cce);
  // byte offset within a word, then word offset within a block
  localparam int block_offset_width = $clog2(data_width / 8) + $clog2(ways);

  // payload carries either the victim info or a sized uncached access
  localparam int req_payload_width = data_width + 2;

  typedef enum logic {
    e_rd = 1'b0,
    e_wr = 1'b1
  } lce_req_type_e;

  typedef enum logic {
    e_cacheable     = 1'b0,
    e_non_cacheable = 1'b1
  } lce_cacheable_e;

  typedef enum logic {
    e_tr_ack  = 1'b0,
    e_coh_ack = 1'b1
  } lce_resp_type_e;

  typedef enum logic [1:0] {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10,
    e_size_8 = 2'b11
  } lce_nc_size_e;

  typedef struct packed {
    logic [way_id_width-1:0]                        lru_way;
    logic                                           lru_dirty;
    logic [req_payload_width-way_id_width-2:0]      pad;
  } lce_req_cached_s;

  typedef struct packed {
    lce_nc_size_e                                   nc_size;
    logic [data_width-1:0]                          data;
  } lce_req_uncached_s;

  // decoded by non_cacheable
  typedef union packed {
    lce_req_cached_s                                cached_view;
    lce_req_uncached_s                              uncached_view;
  } lce_req_payload_u;

  typedef struct packed {
    logic [cce_id_width-1:0]                        dst_id;
    logic [lce_id_width-1:0]                        src_id;
    lce_req_type_e                                  msg_type;
    lce_cacheable_e                                 non_cacheable;
    logic [paddr_width-1:0]                         addr;
    lce_req_payload_u                               payload;
  } lce_req_s;

  typedef struct packed {
    logic [cce_id_width-1:0]                        dst_id;
    logic [lce_id_width-1:0]                        src_id;
    lce_resp_type_e                                 msg_type;
    logic [paddr_width-1:0]                         addr;
  } lce_resp_s;

  typedef struct packed {
    logic [paddr_width-1:0]                         addr;
    logic [way_id_width-1:0]                        lru_way;
    logic [ways-1:0]                                dirty;
    lce_nc_size_e                                   size;
    logic [data_width-1:0]                          store_data;
  } miss_info_s;

  // one-cycle pulses from the command side
  typedef struct packed {
    logic                                           tr_data;
    logic                                           cce_data;
    logic                                           uncached_data;
    logic                                           set_tag;
    logic                                           set_tag_wakeup;
  } fill_event_s;

endpackage

/* hdl/lce_miss_capture.sv */
/*
 * miss capture
 * holds the address and size of the pending miss and the victim way
 * with its dirty bit, and derives the owning CCE
 */
`timescale 1ns/1ps

module lce_miss_capture (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             capture_miss_i,
  input  logic                             capture_victim_i,
  input  lce_pkg::miss_info_s              miss_info_i,
  output logic [lce_pkg::paddr_width-1:0]  addr_o,
  output lce_pkg::lce_nc_size_e            size_o,
  output logic [lce_pkg::cce_id_width-1:0] dst_id_o,
  output logic [lce_pkg::way_id_width-1:0] lru_way_o,
  output logic                             lru_dirty_o
);
  import lce_pkg::*;

  logic [paddr_width-1:0]  addr_r;
  lce_nc_size_e            size_r;
  logic [way_id_width-1:0] lru_way_r;
  logic                    lru_dirty_r;
  logic                    victim_held_r;

  always_ff @(posedge clk_i) begin
    if (capture_miss_i) begin
      addr_r <= miss_info_i.addr;
      size_r <= miss_info_i.size;
    end
  end

  // victim is taken once, in the first request cycle
  always_ff @(posedge clk_i) begin
    if (capture_victim_i && !victim_held_r) begin
      lru_way_r   <= miss_info_i.lru_way;
      lru_dirty_r <= miss_info_i.dirty[miss_info_i.lru_way];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      victim_held_r <= 1'b0;
    end else if (capture_miss_i) begin
      victim_held_r <= 1'b0;
    end else if (capture_victim_i) begin
      victim_held_r <= 1'b1;
    end
  end

  assign addr_o      = addr_r;
  assign size_o      = size_r;
  assign dst_id_o    = addr_r[block_offset_width +: cce_id_width];
  // live values until the victim is registered
  assign lru_way_o   = victim_held_r ? lru_way_r : miss_info_i.lru_way;
  assign lru_dirty_o = victim_held_r ? lru_dirty_r : miss_info_i.dirty[miss_info_i.lru_way];

endmodule

/* hdl/lce_wakeup_tracker.sv */
/*
 * wakeup tracker
 * remembers which fill events arrived while the miss engine sleeps
 */
`timescale 1ns/1ps

module lce_wakeup_tracker (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                track_i,
  input  logic                clear_i,
  input  lce_pkg::fill_event_s fill_i,
  output logic                set_tag_seen_o,
  output logic                tr_seen_o,
  output logic                cce_seen_o
);
  import lce_pkg::*;

  logic set_tag_r;
  logic tr_r;
  logic cce_r;

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      set_tag_r <= 1'b0;
      tr_r      <= 1'b0;
      cce_r     <= 1'b0;
    end else if (track_i) begin
      set_tag_r <= set_tag_r | fill_i.set_tag;
      tr_r      <= tr_r | fill_i.tr_data;
      cce_r     <= cce_r | fill_i.cce_data;
    end
  end

  // same-cycle pulses count too
  assign set_tag_seen_o = set_tag_r | fill_i.set_tag;
  assign tr_seen_o      = tr_r | fill_i.tr_data;
  assign cce_seen_o     = cce_r | fill_i.cce_data;

endmodule

/* hdl/lce_miss_fsm.sv */
/*
 * miss request FSM
 * accepts cache misses and uncached accesses, sends the request to the
 * CCE, sleeps until the fill completes and returns the matching ack
 */
`timescale 1ns/1ps

module lce_miss_fsm (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic [lce_pkg::lce_id_width-1:0] lce_id_i,
  input  logic                             load_miss_i,
  input  logic                             store_miss_i,
  input  logic                             lr_miss_i,
  input  logic                             uncached_load_i,
  input  logic                             uncached_store_i,
  input  lce_pkg::miss_info_s              miss_info_i,
  input  logic [lce_pkg::paddr_width-1:0]  addr_i,
  input  lce_pkg::lce_nc_size_e            size_i,
  input  logic [lce_pkg::cce_id_width-1:0] dst_id_i,
  input  logic [lce_pkg::way_id_width-1:0] lru_way_i,
  input  logic                             lru_dirty_i,
  input  logic                             set_tag_seen_i,
  input  logic                             tr_seen_i,
  input  logic                             cce_seen_i,
  input  lce_pkg::fill_event_s             fill_i,
  output logic                             capture_miss_o,
  output logic                             capture_victim_o,
  output logic                             track_o,
  output logic                             clear_o,
  output logic                             cache_miss_o,
  output lce_pkg::lce_req_s                lce_req_o,
  output logic                             lce_req_v_o,
  input  logic                             lce_req_ready_i,
  output lce_pkg::lce_resp_s               lce_resp_o,
  output logic                             lce_resp_v_o,
  input  logic                             lce_resp_yumi_i
);
  import lce_pkg::*;

  typedef enum logic [2:0] {
    e_ready,
    e_send_cached_req,
    e_send_uncached_load_req,
    e_sleep,
    e_send_tr_ack,
    e_send_coh_ack
  } miss_state_e;

  miss_state_e   state_r, state_n;
  lce_req_type_e req_type_r, req_type_n;
  logic          cached_miss;

  assign cached_miss = load_miss_i | store_miss_i | lr_miss_i;

  always_comb begin
    state_n          = state_r;
    req_type_n       = req_type_r;
    capture_miss_o   = 1'b0;
    capture_victim_o = 1'b0;
    track_o          = 1'b0;
    clear_o          = 1'b0;
    cache_miss_o     = 1'b1;
    lce_req_v_o      = 1'b0;
    lce_resp_v_o     = 1'b0;

    // default word is the held cached request
    lce_req_o                                = '0;
    lce_req_o.dst_id                         = dst_id_i;
    lce_req_o.src_id                         = lce_id_i;
    lce_req_o.msg_type                       = req_type_r;
    lce_req_o.non_cacheable                  = e_cacheable;
    lce_req_o.addr                           = addr_i;
    lce_req_o.payload.cached_view.lru_way    = lru_way_i;
    lce_req_o.payload.cached_view.lru_dirty  = lru_dirty_i;

    lce_resp_o.dst_id   = dst_id_i;
    lce_resp_o.src_id   = lce_id_i;
    lce_resp_o.msg_type = e_tr_ack;
    lce_resp_o.addr     = addr_i;

    case (state_r)
      e_ready: begin
        if (cached_miss) begin
          capture_miss_o = 1'b1;
          clear_o        = 1'b1;
          // lr goes out as a write to get the block exclusive
          req_type_n     = load_miss_i ? e_rd : e_wr;
          state_n        = e_send_cached_req;
        end else if (uncached_load_i) begin
          capture_miss_o = 1'b1;
          clear_o        = 1'b1;
          state_n        = e_send_uncached_load_req;
        end else if (uncached_store_i) begin
          // posted store, cache retries while ready is low
          cache_miss_o                             = ~lce_req_ready_i;
          lce_req_v_o                              = lce_req_ready_i;
          lce_req_o.dst_id = miss_info_i.addr[block_offset_width +: cce_id_width];
          lce_req_o.msg_type                       = e_wr;
          lce_req_o.non_cacheable                  = e_non_cacheable;
          lce_req_o.addr                           = miss_info_i.addr;
          lce_req_o.payload.uncached_view.nc_size  = miss_info_i.size;
          lce_req_o.payload.uncached_view.data     = miss_info_i.store_data;
        end else begin
          cache_miss_o = 1'b0;
        end
      end

      e_send_cached_req: begin
        capture_victim_o = 1'b1;
        lce_req_v_o      = 1'b1;
        state_n          = lce_req_ready_i ? e_sleep : e_send_cached_req;
      end

      e_send_uncached_load_req: begin
        lce_req_v_o                              = 1'b1;
        lce_req_o.msg_type                       = e_rd;
        lce_req_o.non_cacheable                  = e_non_cacheable;
        lce_req_o.payload.uncached_view.nc_size  = size_i;
        lce_req_o.payload.uncached_view.data     = '0;
        state_n = lce_req_ready_i ? e_sleep : e_send_uncached_load_req;
      end

      e_sleep: begin
        track_o = 1'b1;
        if (fill_i.set_tag_wakeup) begin
          state_n = e_send_coh_ack;
        end else if (fill_i.uncached_data) begin
          state_n = e_ready;
        end else if (set_tag_seen_i && tr_seen_i) begin
          state_n = e_send_tr_ack;
        end else if (set_tag_seen_i && cce_seen_i) begin
          state_n = e_send_coh_ack;
        end
      end

      e_send_tr_ack: begin
        lce_resp_v_o        = 1'b1;
        lce_resp_o.msg_type = e_tr_ack;
        state_n             = lce_resp_yumi_i ? e_ready : e_send_tr_ack;
      end

      e_send_coh_ack: begin
        lce_resp_v_o        = 1'b1;
        lce_resp_o.msg_type = e_coh_ack;
        state_n             = lce_resp_yumi_i ? e_ready : e_send_coh_ack;
      end

      default: begin
        cache_miss_o = 1'b0;
        state_n      = e_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= e_ready;
      req_type_r <= e_rd;
    end else begin
      state_r    <= state_n;
      req_type_r <= req_type_n;
    end
  end

endmodule

/* hdl/lce_req_top.sv */
/*
 * LCE miss request engine
 * request FSM with its miss capture and wakeup tracking blocks
 */
`timescale 1ns/1ps

module lce_req_top (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic [lce_pkg::lce_id_width-1:0] lce_id_i,
  input  logic                             load_miss_i,
  input  logic                             store_miss_i,
  input  logic                             lr_miss_i,
  input  logic                             uncached_load_i,
  input  logic                             uncached_store_i,
  input  lce_pkg::miss_info_s              miss_info_i,
  output logic                             cache_miss_o,
  output logic [lce_pkg::paddr_width-1:0]  miss_addr_o,
  input  lce_pkg::fill_event_s             fill_i,
  output lce_pkg::lce_req_s                lce_req_o,
  output logic                             lce_req_v_o,
  input  logic                             lce_req_ready_i,
  output lce_pkg::lce_resp_s               lce_resp_o,
  output logic                             lce_resp_v_o,
  input  logic                             lce_resp_yumi_i
);
  import lce_pkg::*;

  logic                    capture_miss;
  logic                    capture_victim;
  logic                    track;
  logic                    clear;
  logic [paddr_width-1:0]  addr;
  lce_nc_size_e            size;
  logic [cce_id_width-1:0] dst_id;
  logic [way_id_width-1:0] lru_way;
  logic                    lru_dirty;
  logic                    set_tag_seen;
  logic                    tr_seen;
  logic                    cce_seen;

  assign miss_addr_o = addr;

  lce_miss_fsm u_fsm (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .lce_id_i         (lce_id_i),
    .load_miss_i      (load_miss_i),
    .store_miss_i     (store_miss_i),
    .lr_miss_i        (lr_miss_i),
    .uncached_load_i  (uncached_load_i),
    .uncached_store_i (uncached_store_i),
    .miss_info_i      (miss_info_i),
    .addr_i           (addr),
    .size_i           (size),
    .dst_id_i         (dst_id),
    .lru_way_i        (lru_way),
    .lru_dirty_i      (lru_dirty),
    .set_tag_seen_i   (set_tag_seen),
    .tr_seen_i        (tr_seen),
    .cce_seen_i       (cce_seen),
    .fill_i           (fill_i),
    .capture_miss_o   (capture_miss),
    .capture_victim_o (capture_victim),
    .track_o          (track),
    .clear_o          (clear),
    .cache_miss_o     (cache_miss_o),
    .lce_req_o        (lce_req_o),
    .lce_req_v_o      (lce_req_v_o),
    .lce_req_ready_i  (lce_req_ready_i),
    .lce_resp_o       (lce_resp_o),
    .lce_resp_v_o     (lce_resp_v_o),
    .lce_resp_yumi_i  (lce_resp_yumi_i)
  );

  lce_miss_capture u_capture (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .capture_miss_i   (capture_miss),
    .capture_victim_i (capture_victim),
    .miss_info_i      (miss_info_i),
    .addr_o           (addr),
    .size_o           (size),
    .dst_id_o         (dst_id),
    .lru_way_o        (lru_way),
    .lru_dirty_o      (lru_dirty)
  );

  lce_wakeup_tracker u_tracker (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .track_i        (track),
    .clear_i        (clear),
    .fill_i         (fill_i),
    .set_tag_seen_o (set_tag_seen),
    .tr_seen_o      (tr_seen),
    .cce_seen_o     (cce_seen)
  );

endmodule

/* tb/lce_req_chk.sv */
/*
 * protocol checker for the LCE miss request engine
 * bound into the top level
 */
`timescale 1ns/1ps

module lce_req_chk (
  input logic                 clk_i,
  input logic                 reset_i,
  input logic                 cache_miss_i,
  input lce_pkg::fill_event_s fill_i,
  input lce_pkg::lce_req_s    lce_req_i,
  input logic                 lce_req_v_i,
  input logic                 lce_req_ready_i,
  input logic                 lce_resp_v_i,
  input logic                 lce_resp_yumi_i
);

  int assert_fail_count = 0;

  // fills only come back for an outstanding miss
  fill_needs_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    (fill_i != '0) |-> cache_miss_i)
    else begin
      $error("fill pulse while no miss is pending");
      assert_fail_count++;
    end

  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_resp_yumi_i |-> lce_resp_v_i)
    else begin
      $error("response yumi without valid");
      assert_fail_count++;
    end

  // waiting request keeps valid and its word
  req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (lce_req_v_i && !lce_req_ready_i) |=> (lce_req_v_i && $stable(lce_req_i)))
    else begin
      $error("request dropped or changed before ready");
      assert_fail_count++;
    end

endmodule

bind lce_req_top lce_req_chk u_chk (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .cache_miss_i    (cache_miss_o),
  .fill_i          (fill_i),
  .lce_req_i       (lce_req_o),
  .lce_req_v_i     (lce_req_v_o),
  .lce_req_ready_i (lce_req_ready_i),
  .lce_resp_v_i    (lce_resp_v_o),
  .lce_resp_yumi_i (lce_resp_yumi_i)
);

/* tb/tb_lce_req.sv */
/*
 * testbench for the LCE miss request engine
 * drives cached and uncached misses, fill events and both channel handshakes
 */
`timescale 1ns/1ps

module tb_lce_req;
  import lce_pkg::*;

  typedef enum {k_load, k_store, k_lr, k_uc_load, k_uc_store} miss_kind_e;

  logic                    clk_i = 1'b0;
  logic                    reset_i;
  logic [lce_id_width-1:0] lce_id_i;
  logic                    load_miss_i;
  logic                    store_miss_i;
  logic                    lr_miss_i;
  logic                    uncached_load_i;
  logic                    uncached_store_i;
  miss_info_s              miss_info_i;
  logic                    cache_miss_o;
  logic [paddr_width-1:0]  miss_addr_o;
  fill_event_s             fill_i;
  lce_req_s                lce_req_o;
  logic                    lce_req_v_o;
  logic                    lce_req_ready_i;
  lce_resp_s               lce_resp_o;
  logic                    lce_resp_v_o;
  logic                    lce_resp_yumi_i;

  integer    seed;
  int        req_errors = 0;
  int        resp_errors = 0;
  int        ctrl_errors = 0;
  int        timeouts = 0;
  lce_req_s  exp_req_q[$];
  lce_resp_s exp_resp_q[$];
  lce_req_s  exp_req;
  lce_resp_s exp_resp;

  lce_req_top u_lce_req_top (.*);

  always #10 clk_i = ~clk_i;

  // request word as the CCE should see it
  function automatic lce_req_s expected_req(miss_kind_e kind, miss_info_s info,
                                            logic [lce_id_width-1:0] id);
    lce_req_s r;
    r = '0;
    r.dst_id = info.addr[6];
    r.src_id = id;
    r.addr = info.addr;
    r.msg_type = (kind == k_load || kind == k_uc_load) ? e_rd : e_wr;
    if (kind == k_uc_load || kind == k_uc_store) begin
      r.non_cacheable = e_non_cacheable;
      r.payload.uncached_view.nc_size = info.size;
      r.payload.uncached_view.data = (kind == k_uc_store) ? info.store_data : '0;
    end else begin
      r.non_cacheable = e_cacheable;
      r.payload.cached_view.lru_way = info.lru_way;
      r.payload.cached_view.lru_dirty = info.dirty[info.lru_way];
    end
    return r;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("FAILED t=%0t %s exp=%0b got=%0b", $time, name, exp, got);
      ctrl_errors++;
    end
  endtask

  // on_resp picks ack valid over the request handshake
  task automatic wait_for(input bit on_resp, input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while (on_resp ? !lce_resp_v_o : !(lce_req_v_o && lce_req_ready_i)) begin
      n++;
      if (n > 40) begin
        $display("timeout at t=%0t: no %s within 40 cycles", $time, what);
        timeouts++;
        break;
      end
      @(negedge clk_i);
    end
    step();
  endtask

  task automatic new_miss_info();
    lce_id_i = $random(seed);
    miss_info_i.addr = $random(seed);
    miss_info_i.lru_way = $random(seed);
    miss_info_i.dirty = $random(seed);
    miss_info_i.size = lce_nc_size_e'($random(seed) & 3);
    miss_info_i.store_data = {$random(seed), $random(seed)};
  endtask

  task automatic pulse_fill(input fill_event_s ev);
    fill_i = ev;
    step();
    fill_i = '0;
  endtask

  task automatic run_cached(input miss_kind_e kind, input int low, input int order,
                            input int delay);
    lce_resp_s   resp;
    fill_event_s ev;
    new_miss_info();
    exp_req_q.push_back(expected_req(kind, miss_info_i, lce_id_i));
    resp = '0;
    resp.dst_id = miss_info_i.addr[6];
    resp.src_id = lce_id_i;
    resp.addr = miss_info_i.addr;
    resp.msg_type = (order == 0) ? e_tr_ack : e_coh_ack;
    load_miss_i = (kind == k_load);
    store_miss_i = (kind == k_store);
    lr_miss_i = (kind == k_lr);
    #1 check_level("cache_miss_o", cache_miss_o, 1'b1);
    step();
    load_miss_i = 1'b0;
    store_miss_i = 1'b0;
    lr_miss_i = 1'b0;
    lce_req_ready_i = 1'b0;
    if (low > 0) begin
      step();
      // victim already taken so the held request must not change
      miss_info_i.lru_way = $random(seed);
      miss_info_i.dirty = $random(seed);
      repeat (low - 1) step();
    end
    lce_req_ready_i = 1'b1;
    wait_for(1'b0, "cached request handshake");
    lce_req_ready_i = 1'b0;
    exp_resp_q.push_back(resp);
    ev = '0;
    case (order)
      0: begin
        ev.set_tag = 1'b1;
        pulse_fill(ev);
        repeat ($unsigned($random(seed)) % 3) step();
        ev = '0;
        ev.tr_data = 1'b1;
      end
      1: begin
        ev.cce_data = 1'b1;
        pulse_fill(ev);
        repeat ($unsigned($random(seed)) % 3) step();
        ev = '0;
        ev.set_tag = 1'b1;
      end
      2: begin
        ev.cce_data = 1'b1;
        ev.set_tag = 1'b1;
      end
      default: ev.set_tag_wakeup = 1'b1;
    endcase
    pulse_fill(ev);
    wait_for(1'b1, "ack valid");
    assert (miss_addr_o === resp.addr) else begin
      $display("FAILED t=%0t miss_addr_o exp=%h got=%h", $time, resp.addr, miss_addr_o);
      ctrl_errors++;
    end
    repeat (delay) begin
      check_level("cache_miss_o", cache_miss_o, 1'b1);
      step();
    end
    lce_resp_yumi_i = 1'b1;
    step();
    check_level("cache_miss_o", cache_miss_o, 1'b0);
    lce_resp_yumi_i = 1'b0;
  endtask

  task automatic run_uc_load(input int low);
    fill_event_s ev;
    new_miss_info();
    exp_req_q.push_back(expected_req(k_uc_load, miss_info_i, lce_id_i));
    uncached_load_i = 1'b1;
    step();
    uncached_load_i = 1'b0;
    lce_req_ready_i = 1'b0;
    repeat (low) step();
    lce_req_ready_i = 1'b1;
    wait_for(1'b0, "uncached load request handshake");
    lce_req_ready_i = 1'b0;
    repeat (2) step();
    ev = '0;
    ev.uncached_data = 1'b1;
    fill_i = ev;
    step();
    check_level("cache_miss_o", cache_miss_o, 1'b0);
    check_level("lce_resp_v_o", lce_resp_v_o, 1'b0);
    fill_i = '0;
  endtask

  task automatic run_uc_store(input bit ready);
    new_miss_info();
    if (ready) begin
      exp_req_q.push_back(expected_req(k_uc_store, miss_info_i, lce_id_i));
    end
    lce_req_ready_i = ready;
    uncached_store_i = 1'b1;
    #1 check_level("cache_miss_o", cache_miss_o, !ready);
    check_level("lce_req_v_o", lce_req_v_o, ready);
    step();
    uncached_store_i = 1'b0;
    lce_req_ready_i = 1'b0;
  endtask

  // both channels are compared at the falling edge
  always @(negedge clk_i) begin
    if (!reset_i && lce_req_v_o && lce_req_ready_i) begin
      assert (exp_req_q.size() > 0) else begin
        $display("unexpected request at t=%0t: %h", $time, lce_req_o);
        req_errors++;
      end
      if (exp_req_q.size() > 0) begin
        exp_req = exp_req_q.pop_front();
        assert (lce_req_o === exp_req) else begin
          $display("FAILED t=%0t lce_req_o exp=%h got=%h", $time, exp_req, lce_req_o);
          req_errors++;
        end
      end
    end
    if (!reset_i && lce_resp_v_o && lce_resp_yumi_i) begin
      assert (exp_resp_q.size() > 0) else begin
        $display("unexpected response at t=%0t: %h", $time, lce_resp_o);
        resp_errors++;
      end
      if (exp_resp_q.size() > 0) begin
        exp_resp = exp_resp_q.pop_front();
        assert (lce_resp_o === exp_resp) else begin
          $display("FAILED t=%0t lce_resp_o exp=%h got=%h", $time, exp_resp, lce_resp_o);
          resp_errors++;
        end
      end
    end
  end

  initial begin
    int leftover;
    int chk_errors;
    seed = 32'hf126;
    reset_i = 1'b1;
    lce_id_i = '0;
    load_miss_i = 1'b0;
    store_miss_i = 1'b0;
    lr_miss_i = 1'b0;
    uncached_load_i = 1'b0;
    uncached_store_i = 1'b0;
    miss_info_i = '0;
    fill_i = '0;
    lce_req_ready_i = 1'b0;
    lce_resp_yumi_i = 1'b0;
    repeat (16) @(posedge clk_i);
    #2 reset_i = 1'b0;
    step();
    check_level("cache_miss_o", cache_miss_o, 1'b0);
    check_level("lce_req_v_o", lce_req_v_o, 1'b0);
    check_level("lce_resp_v_o", lce_resp_v_o, 1'b0);

    run_cached(k_load, 0, 0, 1);
    run_cached(k_store, 3, 1, 2);
    run_cached(k_lr, 2, 2, 0);
    for (int i = 0; i < 12; i++) begin
      run_cached(miss_kind_e'($unsigned($random(seed)) % 3), $unsigned($random(seed)) % 4,
                 i % 4, $unsigned($random(seed)) % 4);
    end
    run_uc_load(0);
    run_uc_load(3);
    run_uc_store(1'b1);
    run_uc_store(1'b0);
    run_uc_store(1'b1);
    repeat (4) step();

    leftover = exp_req_q.size() + exp_resp_q.size();
    chk_errors = u_lce_req_top.u_chk.assert_fail_count;
    $display("errors: request=%0d response=%0d control=%0d assertion=%0d timeout=%0d %s%0d",
             req_errors, resp_errors, ctrl_errors, chk_errors, timeouts, "unmatched=",
             leftover);
    if (req_errors + resp_errors + ctrl_errors + chk_errors + timeouts + leftover == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
hdl/lce_pkg.sv
hdl/lce_miss_capture.sv
hdl/lce_wakeup_tracker.sv
hdl/lce_miss_fsm.sv
hdl/lce_req_top.sv
tb/lce_req_chk.sv
tb/tb_lce_req.sv

/* Bender.yml */
package:
  name: lce_req

sources:
  - files:
      - hdl/lce_pkg.sv
      - hdl/lce_miss_capture.sv
      - hdl/lce_wakeup_tracker.sv
      - hdl/lce_miss_fsm.sv
      - hdl/lce_req_top.sv
  - target: test
    files:
      - tb/lce_req_chk.sv
      - tb/tb_lce_req.sv
